// ==== hdl/lbp_pkg.sv ====
package lbp_pkg;

  // grayscale pixel
  localparam int PIX_W = 8;

  // frame geometry, raster order with row 0 at the top
  localparam int COLS = 12;
  localparam int ROWS = 10;

  // counter widths for the raster position
  localparam int COL_W = $clog2(COLS);
  localparam int ROW_W = $clog2(ROWS);

  // side of the sliding window, radius 2 around the center
  localparam int WIN = 5;

  // nine pixels of up to 255 each need 12 bits
  localparam int SUM_W = 12;

  // compass directions sampled on each ring
  localparam int NEIGH = 8;

  // riu2 codes run 0..8 for uniform patterns
  localparam int CODE_W = 4;

  // riu2 code given to every pattern with more than two transitions
  localparam int NONUNIFORM = 9;

  // cycles from a strobe to its code:
  // window register 1, bits stage 2, riu2 register 1
  localparam int LATENCY = 4;

endpackage

// ==== hdl/window_5x5.sv ====
`timescale 1ns/1ps

module window_5x5 (
  input  logic                                                   clk,
  input  logic                                                   rst_i,
  input  logic [lbp_pkg::PIX_W-1:0]                              pix_i,
  input  logic                                                   pix_valid_i,
  output logic [lbp_pkg::WIN*lbp_pkg::WIN-1:0][lbp_pkg::PIX_W-1:0] win_o,
  output logic                                                   win_valid_o,
  output logic                                                   win_last_o
);

  // four line memories indexed by column
  // entry 0 holds the oldest row, entry 3 the row just above the current one
  logic [lbp_pkg::PIX_W-1:0] line_mem [lbp_pkg::WIN-1][lbp_pkg::COLS];

  // raster position of the pixel being strobed in
  logic [lbp_pkg::COL_W-1:0] col_q;
  logic [lbp_pkg::ROW_W-1:0] row_q;

  // full image column at col_q, oldest row first, new pixel last
  logic [lbp_pkg::WIN-1:0][lbp_pkg::PIX_W-1:0] column;

  logic col_last;
  logic row_last;
  logic win_full;

  always_comb begin
    for (int i = 0; i < lbp_pkg::WIN - 1; i++) begin
      column[i] = line_mem[i][col_q];
    end
    column[lbp_pkg::WIN-1] = pix_i;
  end

  assign col_last = (col_q == lbp_pkg::COL_W'(lbp_pkg::COLS - 1));
  assign row_last = (row_q == lbp_pkg::ROW_W'(lbp_pkg::ROWS - 1));

  // five rows and five columns seen so far in this frame
  assign win_full = (col_q >= lbp_pkg::COL_W'(lbp_pkg::WIN - 1)) &&
                    (row_q >= lbp_pkg::ROW_W'(lbp_pkg::WIN - 1));

  // each line memory takes the row below it, the newest takes the pixel
  always_ff @(posedge clk) begin
    if (pix_valid_i) begin
      for (int i = 0; i < lbp_pkg::WIN - 1; i++) begin
        line_mem[i][col_q] <= column[i + 1];
      end
    end
  end

  // window moves one column west, new column enters on the east side
  always_ff @(posedge clk) begin
    if (pix_valid_i) begin
      for (int r = 0; r < lbp_pkg::WIN; r++) begin
        for (int c = 0; c < lbp_pkg::WIN - 1; c++) begin
          win_o[r*lbp_pkg::WIN + c] <= win_o[r*lbp_pkg::WIN + c + 1];
        end
        win_o[r*lbp_pkg::WIN + lbp_pkg::WIN - 1] <= column[r];
      end
    end
  end

  // raster counters, wrap to a new frame after the last pixel
  always_ff @(posedge clk) begin
    if (rst_i) begin
      col_q <= '0;
      row_q <= '0;
    end else if (pix_valid_i) begin
      if (col_last) begin
        col_q <= '0;
        if (row_last) begin
          row_q <= '0;
        end else begin
          row_q <= row_q + 1'b1;
        end
      end else begin
        col_q <= col_q + 1'b1;
      end
    end
  end

  // flags line up with the window register they describe
  always_ff @(posedge clk) begin
    if (rst_i) begin
      win_valid_o <= 1'b0;
      win_last_o  <= 1'b0;
    end else begin
      win_valid_o <= pix_valid_i && win_full;
      win_last_o  <= pix_valid_i && col_last && row_last;
    end
  end

  // counters never leave the image, across frames as well
  col_in_range: assert property (@(posedge clk) disable iff (rst_i)
    col_q < lbp_pkg::COL_W'(lbp_pkg::COLS));

  row_in_range: assert property (@(posedge clk) disable iff (rst_i)
    row_q < lbp_pkg::ROW_W'(lbp_pkg::ROWS));

endmodule

// ==== hdl/lbp_bits.sv ====
`timescale 1ns/1ps

module lbp_bits (
  input  logic                                                   clk,
  input  logic                                                   rst_i,
  input  logic [lbp_pkg::WIN*lbp_pkg::WIN-1:0][lbp_pkg::PIX_W-1:0] win_i,
  input  logic                                                   win_valid_i,
  input  logic                                                   win_last_i,
  output logic [lbp_pkg::NEIGH-1:0]                              ni_bits_o,
  output logic [lbp_pkg::NEIGH-1:0]                              rd_bits_o,
  output logic                                                   bits_valid_o,
  output logic                                                   bits_last_o
);

  // window index of the sample at distance radius in direction k
  function automatic int ring_index(input int k, input int radius);
    int dr;
    int dc;
    int mid;
    mid = lbp_pkg::WIN / 2;
    // east side is k 7, 0, 1; west side is k 3, 4, 5
    if (k <= 1 || k == 7) begin
      dc = 1;
    end else if (k >= 3 && k <= 5) begin
      dc = -1;
    end else begin
      dc = 0;
    end
    // north points toward the oldest window row
    if (k >= 1 && k <= 3) begin
      dr = -1;
    end else if (k >= 5) begin
      dr = 1;
    end else begin
      dr = 0;
    end
    return (mid + radius * dr) * lbp_pkg::WIN + mid + radius * dc;
  endfunction

  logic [lbp_pkg::SUM_W-1:0]                     sum_d;
  logic [lbp_pkg::SUM_W-1:0]                     sum_q;
  logic [lbp_pkg::NEIGH-1:0][lbp_pkg::PIX_W-1:0] r1_q;
  logic [lbp_pkg::NEIGH-1:0][lbp_pkg::PIX_W-1:0] r2_q;
  logic                                          valid_q;
  logic                                          last_q;
  logic [lbp_pkg::SUM_W-1:0]                     nine_x [lbp_pkg::NEIGH];
  logic [lbp_pkg::NEIGH-1:0]                     ni_d;
  logic [lbp_pkg::NEIGH-1:0]                     rd_d;

  // 3x3 patch around the center
  always_comb begin
    sum_d = '0;
    for (int r = lbp_pkg::WIN / 2 - 1; r <= lbp_pkg::WIN / 2 + 1; r++) begin
      for (int c = lbp_pkg::WIN / 2 - 1; c <= lbp_pkg::WIN / 2 + 1; c++) begin
        sum_d = sum_d + lbp_pkg::SUM_W'(win_i[r*lbp_pkg::WIN + c]);
      end
    end
  end

  // stage 1: patch sum and both rings, diagonals from the nearest grid pixel
  always_ff @(posedge clk) begin
    if (win_valid_i) begin
      sum_q <= sum_d;
      for (int k = 0; k < lbp_pkg::NEIGH; k++) begin
        r1_q[k] <= win_i[ring_index(k, 1)];
        r2_q[k] <= win_i[ring_index(k, 2)];
      end
    end
  end

  // comparing 9*sample with the sum avoids dividing for the mean
  always_comb begin
    for (int k = 0; k < lbp_pkg::NEIGH; k++) begin
      nine_x[k] = (lbp_pkg::SUM_W'(r2_q[k]) << 3) + lbp_pkg::SUM_W'(r2_q[k]);
      ni_d[k]   = (nine_x[k] >= sum_q);
      rd_d[k]   = (r2_q[k] >= r1_q[k]);
    end
  end

  // stage 2: registered bit patterns
  always_ff @(posedge clk) begin
    if (valid_q) begin
      ni_bits_o <= ni_d;
      rd_bits_o <= rd_d;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      valid_q      <= 1'b0;
      last_q       <= 1'b0;
      bits_valid_o <= 1'b0;
      bits_last_o  <= 1'b0;
    end else begin
      valid_q      <= win_valid_i;
      last_q       <= win_valid_i && win_last_i;
      bits_valid_o <= valid_q;
      bits_last_o  <= last_q;
    end
  end

  // fixed two-cycle pipeline, no stall
  bits_delay: assert property (@(posedge clk) disable iff (rst_i)
    bits_valid_o == $past(win_valid_i, 2));

endmodule

// ==== hdl/riu2_mapping.sv ====
`timescale 1ns/1ps

module riu2_mapping (
  input  logic                        clk,
  input  logic                        rst_i,
  input  logic [lbp_pkg::NEIGH-1:0]   pattern_i,
  input  logic                        valid_i,
  input  logic                        last_i,
  output logic [lbp_pkg::CODE_W-1:0]  code_o,
  output logic                        valid_o,
  output logic                        last_o
);

  logic [lbp_pkg::CODE_W-1:0] trans;
  logic [lbp_pkg::CODE_W-1:0] ones;
  logic                       uniform;

  // circular transitions and population count
  always_comb begin
    trans = '0;
    ones  = '0;
    for (int k = 0; k < lbp_pkg::NEIGH; k++) begin
      trans = trans + lbp_pkg::CODE_W'(pattern_i[k] ^ pattern_i[(k + 1) % lbp_pkg::NEIGH]);
      ones  = ones + lbp_pkg::CODE_W'(pattern_i[k]);
    end
  end

  // uniform means at most one run of ones around the ring
  assign uniform = (trans <= lbp_pkg::CODE_W'(2));

  always_ff @(posedge clk) begin
    if (valid_i) begin
      code_o <= uniform ? ones : lbp_pkg::CODE_W'(lbp_pkg::NONUNIFORM);
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      valid_o <= 1'b0;
      last_o  <= 1'b0;
    end else begin
      valid_o <= valid_i;
      last_o  <= valid_i && last_i;
    end
  end

  code_range: assert property (@(posedge clk) disable iff (rst_i)
    valid_o |-> code_o <= lbp_pkg::CODE_W'(lbp_pkg::NONUNIFORM));

  last_with_valid: assert property (@(posedge clk) disable iff (rst_i)
    last_o |-> valid_o);

endmodule

// ==== hdl/r2_nird.sv ====
`timescale 1ns/1ps

module r2_nird (
  input  logic                       clk,
  input  logic                       rst_i,
  input  logic [lbp_pkg::PIX_W-1:0]  pix_i,
  input  logic                       pix_valid_i,
  output logic [lbp_pkg::CODE_W-1:0] ni_o,
  output logic [lbp_pkg::CODE_W-1:0] rd_o,
  output logic                       code_valid_o,
  output logic                       frame_done_o
);

  logic [lbp_pkg::WIN*lbp_pkg::WIN-1:0][lbp_pkg::PIX_W-1:0] win;
  logic                                                   win_valid;
  logic                                                   win_last;

  logic [lbp_pkg::NEIGH-1:0] ni_bits;
  logic [lbp_pkg::NEIGH-1:0] rd_bits;
  logic                      bits_valid;
  logic                      bits_last;

  window_5x5 u_window (
    .clk         (clk),
    .rst_i       (rst_i),
    .pix_i       (pix_i),
    .pix_valid_i (pix_valid_i),
    .win_o       (win),
    .win_valid_o (win_valid),
    .win_last_o  (win_last)
  );

  lbp_bits u_bits (
    .clk          (clk),
    .rst_i        (rst_i),
    .win_i        (win),
    .win_valid_i  (win_valid),
    .win_last_i   (win_last),
    .ni_bits_o    (ni_bits),
    .rd_bits_o    (rd_bits),
    .bits_valid_o (bits_valid),
    .bits_last_o  (bits_last)
  );

  // ni mapper carries the strobe and the frame marker
  riu2_mapping u_riu2_ni (
    .clk       (clk),
    .rst_i     (rst_i),
    .pattern_i (ni_bits),
    .valid_i   (bits_valid),
    .last_i    (bits_last),
    .code_o    (ni_o),
    .valid_o   (code_valid_o),
    .last_o    (frame_done_o)
  );

  // same timing as the ni mapper, flags not needed
  riu2_mapping u_riu2_rd (
    .clk       (clk),
    .rst_i     (rst_i),
    .pattern_i (rd_bits),
    .valid_i   (bits_valid),
    .last_i    (bits_last),
    .code_o    (rd_o),
    .valid_o   (),
    .last_o    ()
  );

endmodule

// ==== include/nird_ref.svh ====
`ifndef NIRD_REF_SVH
`define NIRD_REF_SVH

// whole frame as stored by the testbench and indexed [row][col]
typedef logic [lbp_pkg::PIX_W-1:0] image_t [lbp_pkg::ROWS][lbp_pkg::COLS];

// column step for direction k counted counter-clockwise from east
function automatic int col_step(input int k);
  case (k)
    0, 1, 7: return 1;
    3, 4, 5: return -1;
    default: return 0;
  endcase
endfunction

// row step for direction k where rows grow downward and north is negative
function automatic int row_step(input int k);
  case (k)
    1, 2, 3: return -1;
    5, 6, 7: return 1;
    default: return 0;
  endcase
endfunction

function automatic logic [lbp_pkg::CODE_W-1:0] riu2_code(
    input logic [lbp_pkg::NEIGH-1:0] pattern);
  int u;
  int ones;
  u = 0;
  ones = 0;
  for (int k = 0; k < lbp_pkg::NEIGH; k++) begin
    u += int'(pattern[k] != pattern[(k + 1) % lbp_pkg::NEIGH]);
    ones += int'(pattern[k]);
  end
  if (u <= 2) begin
    return lbp_pkg::CODE_W'(ones);
  end
  return lbp_pkg::CODE_W'(lbp_pkg::NONUNIFORM);
endfunction

// ni pattern for the center pixel (r, c) from radius-2 samples against the 3x3 mean
function automatic logic [lbp_pkg::NEIGH-1:0] ni_pattern(
    input image_t img, input int r, input int c);
  int sum;
  int s2;
  logic [lbp_pkg::NEIGH-1:0] bits;
  sum = 0;
  for (int dr = -1; dr <= 1; dr++) begin
    for (int dc = -1; dc <= 1; dc++) begin
      sum += int'(img[r + dr][c + dc]);
    end
  end
  for (int k = 0; k < lbp_pkg::NEIGH; k++) begin
    s2 = int'(img[r + 2 * row_step(k)][c + 2 * col_step(k)]);
    bits[k] = (9 * s2 >= sum);
  end
  return bits;
endfunction

// rd pattern for the center pixel (r, c) from radius 2 against radius 1
function automatic logic [lbp_pkg::NEIGH-1:0] rd_pattern(
    input image_t img, input int r, input int c);
  logic [lbp_pkg::NEIGH-1:0] bits;
  logic [lbp_pkg::PIX_W-1:0] s1;
  logic [lbp_pkg::PIX_W-1:0] s2;
  for (int k = 0; k < lbp_pkg::NEIGH; k++) begin
    s1 = img[r + row_step(k)][c + col_step(k)];
    s2 = img[r + 2 * row_step(k)][c + 2 * col_step(k)];
    bits[k] = (s2 >= s1);
  end
  return bits;
endfunction

`endif

// ==== verification/r2_nird_tb.sv ====
`timescale 1ns/1ps

module r2_nird_tb;

  `include "nird_ref.svh"

  localparam int CLK_NS = 40;
  localparam int FRAME_CODES = (lbp_pkg::ROWS - 4) * (lbp_pkg::COLS - 4);
  // seven frames over all tests at up to four cycles per pixel
  localparam int WATCHDOG_NS = (7 * lbp_pkg::ROWS * lbp_pkg::COLS * 4 + 200) * CLK_NS;

  localparam int IMG_FLAT = 0;
  localparam int IMG_RANDOM = 1;
  localparam int IMG_CHECKER = 2;
  localparam int IMG_EDGE = 3;

  typedef struct packed {
    logic                       last;
    logic [31:0]                due;
    logic [lbp_pkg::CODE_W-1:0] ni;
    logic [lbp_pkg::CODE_W-1:0] rd;
  } expect_t;

  logic                       clk;
  logic                       rst_i;
  logic [lbp_pkg::PIX_W-1:0]  pix_i;
  logic                       pix_valid_i;
  logic [lbp_pkg::CODE_W-1:0] ni_o;
  logic [lbp_pkg::CODE_W-1:0] rd_o;
  logic                       code_valid_o;
  logic                       frame_done_o;

  image_t     img;
  expect_t    exp_q[$];
  expect_t    head;
  logic       have_head = 1'b0;
  logic       pop_pending = 1'b0;
  int         cyc;
  int         errors;
  int         codes_seen;
  int         nonuni_exp;
  int         tests_run;
  int         tests_failed;
  int         test_err_start;
  int         test_codes_start;
  int         seed = 11885;
  string      test_name = "reset_idle";

  r2_nird r2_nird_inst (
    .clk          (clk),
    .rst_i        (rst_i),
    .pix_i        (pix_i),
    .pix_valid_i  (pix_valid_i),
    .ni_o         (ni_o),
    .rd_o         (rd_o),
    .code_valid_o (code_valid_o),
    .frame_done_o (frame_done_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  // every code the DUT puts out, expected or not
  always @(posedge clk) begin
    if (!rst_i && code_valid_o) begin
      codes_seen <= codes_seen + 1;
    end
  end

  // queue head moves just after the falling edge and away from the sampling edge
  always @(negedge clk) begin
    #1;
    if (pop_pending && exp_q.size() > 0) begin
      void'(exp_q.pop_front());
    end
    have_head = (exp_q.size() > 0);
    if (have_head) begin
      head = exp_q[0];
    end
    pop_pending = !rst_i && code_valid_o && have_head;
  end

  reset_clears: assert property (@(posedge clk) rst_i |=> !code_valid_o && !frame_done_o)
    else begin
      $display("reset did not clear code_valid_o or frame_done_o");
      errors++;
    end

  no_spurious: assert property (@(posedge clk) disable iff (rst_i) code_valid_o |-> have_head)
    else begin
      $display("%s: code_valid_o rose with no code expected", test_name);
      errors++;
    end

  ni_match: assert property (@(posedge clk) disable iff (rst_i)
    code_valid_o && have_head |-> ni_o == head.ni)
    else begin
      $display("error %s: ni expected %0d, actual %0d", test_name, head.ni, $sampled(ni_o));
      errors++;
    end

  rd_match: assert property (@(posedge clk) disable iff (rst_i)
    code_valid_o && have_head |-> rd_o == head.rd)
    else begin
      $display("error %s: rd expected %0d, actual %0d", test_name, head.rd, $sampled(rd_o));
      errors++;
    end

  on_time: assert property (@(posedge clk) disable iff (rst_i)
    code_valid_o && have_head |-> cyc == head.due)
    else begin
      $display("error %s: code cycle expected %0d, actual %0d", test_name, head.due,
               $sampled(cyc));
      errors++;
    end

  done_match: assert property (@(posedge clk) disable iff (rst_i)
    code_valid_o && have_head |-> frame_done_o == head.last)
    else begin
      $display("error %s: frame_done_o expected %0d, actual %0d", test_name, head.last,
               $sampled(frame_done_o));
      errors++;
    end

  done_with_code: assert property (@(posedge clk) disable iff (rst_i)
    frame_done_o |-> code_valid_o)
    else begin
      $display("%s: frame_done_o pulsed without a code", test_name);
      errors++;
    end

  task automatic fill_image(input int kind);
    for (int r = 0; r < lbp_pkg::ROWS; r++) begin
      for (int c = 0; c < lbp_pkg::COLS; c++) begin
        case (kind)
          IMG_FLAT:    img[r][c] = 8'd77;
          IMG_RANDOM:  img[r][c] = lbp_pkg::PIX_W'($random(seed));
          // 2x2 blocks so that radius-2 samples alternate around the ring
          IMG_CHECKER: img[r][c] = ((r / 2 + c / 2) % 2 == 1) ? 8'd200 : 8'd50;
          default:     img[r][c] = (c < lbp_pkg::COLS / 2) ? 8'd40 : 8'd180;
        endcase
      end
    end
  endtask

  task automatic push_expect(input int r, input int c, input logic last);
    expect_t e;
    e.last = last;
    e.due = cyc + lbp_pkg::LATENCY;
    e.ni = riu2_code(ni_pattern(img, r, c));
    e.rd = riu2_code(rd_pattern(img, r, c));
    if (e.ni == lbp_pkg::CODE_W'(lbp_pkg::NONUNIFORM) ||
        e.rd == lbp_pkg::CODE_W'(lbp_pkg::NONUNIFORM)) begin
      nonuni_exp++;
    end
    exp_q.push_back(e);
  endtask

  // starts and ends on a falling edge
  task automatic stream_frame(input int max_gap);
    int gap;
    for (int r = 0; r < lbp_pkg::ROWS; r++) begin
      for (int c = 0; c < lbp_pkg::COLS; c++) begin
        pix_i = img[r][c];
        pix_valid_i = 1'b1;
        // this pixel completes the window centered two rows and columns back
        if (r >= 4 && c >= 4) begin
          push_expect(r - 2, c - 2, r == lbp_pkg::ROWS - 1 && c == lbp_pkg::COLS - 1);
        end
        @(negedge clk);
        pix_valid_i = 1'b0;
        gap = (max_gap > 0) ? int'({$random(seed)} % (max_gap + 1)) : 0;
        repeat (gap) @(negedge clk);
      end
    end
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    test_err_start = errors;
    test_codes_start = codes_seen;
  endtask

  task automatic end_test(input int exp_codes);
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
    repeat (lbp_pkg::LATENCY + 2) @(negedge clk);
    assert (codes_seen - test_codes_start == exp_codes)
      else begin
        $display("error %s: code count expected %0d, actual %0d", test_name, exp_codes,
                 codes_seen - test_codes_start);
        errors++;
      end
    tests_run++;
    if (errors != test_err_start) begin
      tests_failed++;
    end
    $display("test %s: %s", test_name, (errors == test_err_start) ? "passed" : "failed");
  endtask

  initial begin
    rst_i = 1'b1;
    pix_i = '0;
    pix_valid_i = 1'b0;
    begin_test("reset_idle");
    repeat (5) @(negedge clk);
    rst_i = 1'b0;
    repeat (10) @(negedge clk);
    end_test(0);

    begin_test("flat_image");
    fill_image(IMG_FLAT);
    stream_frame(3);
    end_test(FRAME_CODES);

    begin_test("random_gaps");
    fill_image(IMG_RANDOM);
    stream_frame(3);
    end_test(FRAME_CODES);

    begin_test("back_to_back");
    fill_image(IMG_RANDOM);
    stream_frame(0);
    end_test(FRAME_CODES);

    begin_test("nonuniform");
    nonuni_exp = 0;
    fill_image(IMG_CHECKER);
    stream_frame(3);
    assert (nonuni_exp > 0)
      else begin
        $display("%s: checkerboard produced no non-uniform expected code", test_name);
        errors++;
      end
    fill_image(IMG_EDGE);
    stream_frame(3);
    end_test(2 * FRAME_CODES);

    begin_test("two_frames");
    fill_image(IMG_RANDOM);
    stream_frame(3);
    fill_image(IMG_RANDOM);
    stream_frame(3);
    end_test(2 * FRAME_CODES);

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: codes still missing after %0d ns in test %s", WATCHDOG_NS, test_name);
    $display("Some tests failed");
    $finish;
  end

endmodule

// ==== filelist.f ====
+incdir+include
hdl/lbp_pkg.sv
hdl/window_5x5.sv
hdl/lbp_bits.sv
hdl/riu2_mapping.sv
hdl/r2_nird.sv
verification/r2_nird_tb.sv

// ==== Makefile ====
# Verilator build and run of the r2_nird testbench

VERILATOR ?= verilator
TOP       ?= r2_nird_tb
FLAGS     ?= --binary --timing --assert --timescale 1ns/1ps
LOG       ?= sim.log

FILELIST := filelist.f
SRCS     := $(shell grep -v '^+' $(FILELIST))
HDRS     := $(wildcard include/*.svh)
BIN      := obj_dir/V$(TOP)

.PHONY: all build run check clean

all: check

build: $(BIN)

# rebuilt only when the file list or a source changes
$(BIN): $(FILELIST) $(SRCS) $(HDRS)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)

check: run
	@if grep -q "Some tests failed" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; exit 1; \
	elif ! grep -q "All tests passed" $(LOG); then \
	  echo "simulation ended without a pass line, see $(LOG)"; exit 1; \
	else \
	  echo "simulation passed"; \
	fi

clean:
	rm -rf obj_dir $(LOG)
